//--- sn9_macros.svh
//////////////////////////////
// board timing constants shared by the sn9 blocks
// include in any module that counts clocks, bits,
// microseconds or milliseconds
//////////////////////////////
`ifndef SN9_MACROS_SVH
`define SN9_MACROS_SVH

// oscillator straight into the fabric, no pll
`define SN9_CLOCK_HZ 27000000

`define SN9_BAUD     115200               // console line rate, 8N1

// clocks per uart bit, rounded to nearest
`define SN9_BIT_CLKS ((`SN9_CLOCK_HZ + (`SN9_BAUD / 2)) / `SN9_BAUD)

`define SN9_RST_US   4                    // reset stretch, in us strobes

// rx activity led hold time, counted in ms strobes
`define SN9_ACT_MS   2

`endif

//--- sn9_sys_pkg.sv
//////////////////////////////
// system control types
// one bundle carries the resets and the timebase
// strobes from the system controller to all blocks
//////////////////////////////
package sn9_sys_pkg;

   // driven only by the system controller
   typedef struct packed
   {
      logic rst;                    // stretched system reset, active high
      logic pwr_rst;                // power-on reset, follows rst_n
      logic us;                     // one cycle every microsecond
      logic ms;                     // one cycle every millisecond
   } sys_ctl_t;

endpackage

//--- sn9_con_pkg.sv
//////////////////////////////
// serial console types
// byte strobe bundle between uart and console,
// console states and command opcodes
//////////////////////////////
package sn9_con_pkg;

   // one byte, valid only in the strobe cycle
   typedef struct packed
   {
      logic       stb;              // single-cycle strobe
      logic [7:0] dat;              // byte value
   } ser_byte_t;

   typedef enum logic [1:0]
   {
      IDLE,                         // waiting for a command byte
      LED_ARG,                      // next byte is the led word
      REPLY_HI,                     // time high byte pending
      REPLY_LO                      // low byte or echo pending
   } con_state_e;

   // opcodes are the ascii command bytes
   typedef enum logic [7:0]
   {
      OP_ECHO = 8'h00,              // anything not listed below
      OP_LED  = 8'h4C,              // 'L'
      OP_TIME = 8'h54               // 'T'
   } con_op_e;

endpackage

//--- sn9_sysctl.sv
//////////////////////////////
// system controller
// merges power-on reset with the synchronized
// reset button, stretches the result, and makes the
// microsecond and millisecond strobes for all blocks
//////////////////////////////
`timescale 1ns/1ps
`include "sn9_macros.svh"

module sn9_sysctl
(
   input  logic                  sys_clk_p,      // system clock
   input  logic                  rst_n,          // power-on reset, active low
   input  logic                  reset_btn_n,    // board button, asynchronous
   output sn9_sys_pkg::sys_ctl_t sys_ctl         // resets and strobes
);

localparam int US_CLKS = `SN9_CLOCK_HZ / 1000000;
localparam int UW      = $clog2(US_CLKS);
localparam int RW      = $clog2(`SN9_RST_US + 1);

localparam logic [UW-1:0] US_LAST  = UW'(US_CLKS - 1);
localparam logic [9:0]    MS_LAST  = 10'd999;          // thousand us per ms
localparam logic [RW-1:0] RST_LOAD = RW'(`SN9_RST_US);

logic [1:0]    btn_sync;                // two-flop button synchronizer
logic          pwr_q;                   // registered power-on reset
logic          rst_q;                   // stretched reset
logic [RW-1:0] rst_cnt;                 // us strobes left in stretch
logic [UW-1:0] us_cnt;                  // clock prescaler
logic [9:0]    ms_cnt;                  // us prescaler
logic          us_q;
logic          ms_q;

always_ff @(posedge sys_clk_p)
begin
   if (!rst_n)
   begin
      btn_sync <= 2'b00;
      pwr_q    <= 1'b1;
   end
   else
   begin
      btn_sync <= {btn_sync[0], ~reset_btn_n};   // pressed is high here
      pwr_q    <= 1'b0;
   end
end

// any press restarts the whole stretch
always_ff @(posedge sys_clk_p)
begin
   if (!rst_n || btn_sync[1])
   begin
      rst_cnt <= RST_LOAD;
      rst_q   <= 1'b1;
   end
   else
   begin
      if (us_q && rst_cnt != '0)
         rst_cnt <= rst_cnt - 1'b1;
      rst_q <= (rst_cnt != '0);                  // drops one cycle after last us
   end
end

always_ff @(posedge sys_clk_p)
begin
   if (!rst_n)
   begin
      us_cnt <= '0;
      ms_cnt <= '0;
      us_q   <= 1'b0;
      ms_q   <= 1'b0;
   end
   else
   begin
      us_q <= (us_cnt == US_LAST);
      ms_q <= 1'b0;
      if (us_cnt == US_LAST)
         us_cnt <= '0;
      else
         us_cnt <= us_cnt + 1'b1;
      if (us_q)                                  // ms counts us strobes only
      begin
         ms_q <= (ms_cnt == MS_LAST);
         if (ms_cnt == MS_LAST)
            ms_cnt <= '0;
         else
            ms_cnt <= ms_cnt + 1'b1;
      end
   end
end

assign sys_ctl = '{rst: rst_q, pwr_rst: pwr_q, us: us_q, ms: ms_q};

endmodule

//--- sn9_uart_rx.sv
//////////////////////////////
// uart receiver, 8N1
// samples each bit at its mid-point and gives one
// strobe per good frame, a cycle after the stop bit
// mid-point; frames with a low stop bit are dropped
//////////////////////////////
`timescale 1ns/1ps
`include "sn9_macros.svh"

module sn9_uart_rx
(
   input  logic                   sys_clk_p,     // system clock
   input  sn9_sys_pkg::sys_ctl_t  sys_ctl,       // rst used as local reset
   input  logic                   rxd,           // serial line, asynchronous
   output sn9_con_pkg::ser_byte_t rx_byte        // received byte strobe
);

localparam int BIT_CLKS = `SN9_BIT_CLKS;
localparam int CW       = $clog2(BIT_CLKS);

localparam logic [CW-1:0] BIT_LAST  = CW'(BIT_CLKS - 1);
localparam logic [CW-1:0] HALF_LAST = CW'(BIT_CLKS / 2 - 1);

logic [1:0]    rxd_sync;                // line synchronizer
logic          busy;                    // inside a frame
logic [CW-1:0] clk_cnt;                 // clocks to next sample point
logic [3:0]    bit_cnt;                 // 0 start, 1..8 data, 9 stop
logic [7:0]    shreg;                   // lsb arrives first
logic          stb_q;

always_ff @(posedge sys_clk_p)
begin
   if (sys_ctl.rst)
      rxd_sync <= 2'b11;                // idle line is high
   else
      rxd_sync <= {rxd_sync[0], rxd};
end

always_ff @(posedge sys_clk_p)
begin
   if (sys_ctl.rst)
   begin
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
      stb_q   <= 1'b0;
   end
   else
   begin
      stb_q <= 1'b0;
      if (!busy)
      begin
         if (!rxd_sync[1])              // start edge
         begin
            busy    <= 1'b1;
            clk_cnt <= HALF_LAST;       // align to middle of start bit
            bit_cnt <= '0;
         end
      end
      else if (clk_cnt != '0)
         clk_cnt <= clk_cnt - 1'b1;
      else
      begin
         clk_cnt <= BIT_LAST;
         bit_cnt <= bit_cnt + 1'b1;
         if (bit_cnt == 4'd0)
            busy <= ~rxd_sync[1];       // start gone high, was a glitch
         else if (bit_cnt == 4'd9)
         begin
            busy  <= 1'b0;
            stb_q <= rxd_sync[1];       // framing error gives no strobe
         end
         else
            shreg <= {rxd_sync[1], shreg[7:1]};
      end
   end
end

assign rx_byte = '{stb: stb_q, dat: shreg};

endmodule

//--- sn9_console.sv
//////////////////////////////
// serial debug console in the cpu slot
// 'L' + byte sets the led word, 'T' answers with
// the 16-bit ms uptime high byte first, every other
// byte is echoed; replies wait on the tx busy level
//////////////////////////////
`timescale 1ns/1ps

module sn9_console
(
   input  logic                   sys_clk_p,     // system clock
   input  sn9_sys_pkg::sys_ctl_t  sys_ctl,       // rst and ms strobe used
   input  sn9_con_pkg::ser_byte_t rx_byte,       // from uart receiver
   input  logic                   tx_busy,       // transmitter back-pressure
   output sn9_con_pkg::ser_byte_t tx_byte,       // to uart transmitter
   output logic [7:0]             leds           // led word
);

import sn9_con_pkg::*;

con_state_e  state;
con_op_e     op;                        // decoded rx byte
logic [15:0] uptime;                    // ms since end of reset
logic [15:0] rep_q;                     // time reply, or held echo in [7:0]
logic [7:0]  led_q;
logic        tx_stb_q;
logic [7:0]  tx_dat_q;
logic        can_send;                  // tx idle and not just strobed
logic        send;
logic [7:0]  send_dat;

always_comb
begin
   case (rx_byte.dat)
      OP_LED:  op = OP_LED;
      OP_TIME: op = OP_TIME;
      default: op = OP_ECHO;
   endcase
end

// busy rises only the cycle after a strobe, so own strobe blocks too
assign can_send = ~tx_busy & ~tx_stb_q;

always_comb
begin
   send     = 1'b0;
   send_dat = rep_q[7:0];
   case (state)
      IDLE:
      begin
         send     = rx_byte.stb && op == OP_ECHO && can_send;   // direct echo
         send_dat = rx_byte.dat;
      end
      REPLY_HI:
      begin
         send     = can_send;
         send_dat = rep_q[15:8];
      end
      REPLY_LO: send = can_send;
      default:  send = 1'b0;
   endcase
end

always_ff @(posedge sys_clk_p)
begin
   if (sys_ctl.rst)
      uptime <= '0;
   else if (sys_ctl.ms)
      uptime <= uptime + 1'b1;
end

always_ff @(posedge sys_clk_p)
begin
   if (sys_ctl.rst)
   begin
      state    <= IDLE;
      led_q    <= '0;
      tx_stb_q <= 1'b0;
   end
   else
   begin
      tx_stb_q <= send;
      case (state)
         IDLE:
            if (rx_byte.stb)
            begin
               if (op == OP_LED)
                  state <= LED_ARG;
               else if (op == OP_TIME)
                  state <= REPLY_HI;
               else if (!send)
                  state <= REPLY_LO;    // echo held until tx frees up
            end
         LED_ARG:
            if (rx_byte.stb)
            begin
               led_q <= rx_byte.dat;
               state <= IDLE;
            end
         REPLY_HI: if (send) state <= REPLY_LO;
         default:  if (send) state <= IDLE;   // rx bytes dropped meanwhile
      endcase
   end
end

always_ff @(posedge sys_clk_p)
begin
   if (state == IDLE && rx_byte.stb)
   begin
      if (op == OP_TIME)
         rep_q <= uptime;               // latch value at command time
      else
         rep_q[7:0] <= rx_byte.dat;
   end
   if (send)
      tx_dat_q <= send_dat;
end

assign tx_byte = '{stb: tx_stb_q, dat: tx_dat_q};
assign leds    = led_q;

endmodule

//--- sn9_uart_tx.sv
//////////////////////////////
// uart transmitter, 8N1
// takes a byte on its strobe while not busy; busy
// rises the next cycle and falls at end of stop bit
//////////////////////////////
`timescale 1ns/1ps
`include "sn9_macros.svh"

module sn9_uart_tx
(
   input  logic                   sys_clk_p,     // system clock
   input  sn9_sys_pkg::sys_ctl_t  sys_ctl,       // rst used as local reset
   input  sn9_con_pkg::ser_byte_t tx_byte,       // byte strobe from console
   output logic                   txd,           // serial line
   output logic                   tx_busy        // frame in progress
);

localparam int BIT_CLKS = `SN9_BIT_CLKS;
localparam int CW       = $clog2(BIT_CLKS);

localparam logic [CW-1:0] BIT_LAST = CW'(BIT_CLKS - 1);

logic [9:0]    shreg;                   // stop, data, start; bit 0 on line
logic [3:0]    bit_cnt;                 // shifts left in this frame
logic [CW-1:0] clk_cnt;
logic          busy_q;

always_ff @(posedge sys_clk_p)
begin
   if (sys_ctl.rst)
   begin
      shreg   <= '1;                    // line idles high
      bit_cnt <= '0;
      clk_cnt <= '0;
      busy_q  <= 1'b0;
   end
   else if (!busy_q)
   begin
      if (tx_byte.stb)
      begin
         shreg   <= {1'b1, tx_byte.dat, 1'b0};
         bit_cnt <= 4'd9;
         clk_cnt <= BIT_LAST;
         busy_q  <= 1'b1;
      end
   end
   else if (clk_cnt != '0)
      clk_cnt <= clk_cnt - 1'b1;
   else if (bit_cnt == '0)
      busy_q <= 1'b0;                   // stop bit finished
   else
   begin
      shreg   <= {1'b1, shreg[9:1]};    // shift in idle level
      bit_cnt <= bit_cnt - 1'b1;
      clk_cnt <= BIT_LAST;
   end
end

assign txd     = shreg[0];
assign tx_busy = busy_q;

endmodule

//--- sn9_led_drv.sv
//////////////////////////////
// board led output stage
// registers the led word onto the board leds and
// drives led 0 as a stretched rx activity light
//////////////////////////////
`timescale 1ns/1ps
`include "sn9_macros.svh"

module sn9_led_drv
(
   input  logic                   sys_clk_p,     // system clock
   input  sn9_sys_pkg::sys_ctl_t  sys_ctl,       // rst and ms strobe used
   input  logic [7:0]             leds,          // led word, bits 5:1 shown
   input  sn9_con_pkg::ser_byte_t rx_byte,       // strobe marks rx activity
   output logic [5:0]             sys_led        // board leds
);

localparam int AW = $clog2(`SN9_ACT_MS + 1);

localparam logic [AW-1:0] ACT_LOAD = AW'(`SN9_ACT_MS);

logic [5:1]    led_q;
logic [AW-1:0] act_cnt;                 // ms left on activity light

always_ff @(posedge sys_clk_p)
begin
   if (sys_ctl.rst)
   begin
      led_q   <= '0;
      act_cnt <= '0;
   end
   else
   begin
      led_q <= leds[5:1];               // bits 7, 6 and 0 have no led
      if (rx_byte.stb)
         act_cnt <= ACT_LOAD;           // retrigger on every byte
      else if (sys_ctl.ms && act_cnt != '0)
         act_cnt <= act_cnt - 1'b1;
   end
end

assign sys_led = {led_q, act_cnt != '0};

endmodule

//--- sn9_top.sv
//////////////////////////////
// board top for the sn9 board-support subsystem
// system controller and uart receiver feed the
// console in the cpu slot; uart transmitter and
// led stage drive the board pins
//////////////////////////////
`timescale 1ns/1ps

module sn9_top
(
   input  logic       sys_clk_p,        // board oscillator, no pll
   input  logic       rst_n,            // power-on reset
   input  logic       reset_btn_n,      // reset push button
   input  logic       uart_rxd,         // serial in
   output logic       uart_txd,         // serial out
   output logic [5:0] sys_led           // board leds
);

import sn9_sys_pkg::*;
import sn9_con_pkg::*;

sys_ctl_t   sys_ctl;                    // resets and strobes to all blocks
ser_byte_t  rx_byte;                    // receiver to console and leds
ser_byte_t  tx_byte;                    // console to transmitter
logic       tx_busy;
logic [7:0] leds;                       // console led word

sn9_sysctl u_sysctl
(
   .sys_clk_p   (sys_clk_p),
   .rst_n       (rst_n),
   .reset_btn_n (reset_btn_n),
   .sys_ctl     (sys_ctl)
);

sn9_uart_rx u_uart_rx
(
   .sys_clk_p (sys_clk_p),
   .sys_ctl   (sys_ctl),
   .rxd       (uart_rxd),
   .rx_byte   (rx_byte)
);

sn9_console u_console
(
   .sys_clk_p (sys_clk_p),
   .sys_ctl   (sys_ctl),
   .rx_byte   (rx_byte),
   .tx_busy   (tx_busy),
   .tx_byte   (tx_byte),
   .leds      (leds)
);

sn9_uart_tx u_uart_tx
(
   .sys_clk_p (sys_clk_p),
   .sys_ctl   (sys_ctl),
   .tx_byte   (tx_byte),
   .txd       (uart_txd),
   .tx_busy   (tx_busy)
);

sn9_led_drv u_led_drv
(
   .sys_clk_p (sys_clk_p),
   .sys_ctl   (sys_ctl),
   .leds      (leds),
   .rx_byte   (rx_byte),
   .sys_led   (sys_led)
);

endmodule

//--- sn9_properties.sv
//////////////////////////////
// concurrent assertions for the sn9 top
// bound into sn9_top, watches the board pins and the
// console byte strobes; failures are counted in fail_cnt
//////////////////////////////
`timescale 1ns/1ps
`include "sn9_macros.svh"

module sn9_properties
(
   input logic                   sys_clk_p,
   input logic                   rst_n,
   input logic                   uart_txd,
   input logic [5:0]             sys_led,
   input sn9_sys_pkg::sys_ctl_t  sys_ctl,
   input sn9_con_pkg::ser_byte_t rx_byte,
   input sn9_con_pkg::ser_byte_t tx_byte,
   input logic                   tx_busy,
   input logic [7:0]             leds
);

import sn9_con_pkg::*;

localparam int ACT_MS = `SN9_ACT_MS;

int   fail_cnt = 0;                     // read by the testbench
logic off;                              // any reset active
logic seen_rx;                          // a frame came in since reset
logic busy_d;                           // tx busy or strobe last cycle
logic l_cand;                           // 'L' taken as a command
logic l_wait;                           // waiting for the led argument
logic l_tail;                           // cycle after the argument
int   ms_idle;                          // ms strobes since last rx byte

assign off = !rst_n || sys_ctl.rst;

// console is idle when tx was free for two cycles
assign l_cand = rx_byte.stb && rx_byte.dat == OP_LED && !tx_busy && !tx_byte.stb && !busy_d;

always_ff @(posedge sys_clk_p)
begin
   if (sys_ctl.rst)
   begin
      seen_rx <= 1'b0;
      busy_d  <= 1'b0;
      l_wait  <= 1'b0;
      l_tail  <= 1'b0;
      ms_idle <= ACT_MS;                // activity light is off after reset
   end
   else
   begin
      busy_d <= tx_busy | tx_byte.stb;
      l_tail <= l_wait & rx_byte.stb;
      if (rx_byte.stb)
         seen_rx <= 1'b1;
      if (l_cand)
         l_wait <= 1'b1;
      else if (rx_byte.stb)
         l_wait <= 1'b0;                // argument byte arrived
      if (rx_byte.stb)
         ms_idle <= 0;
      else if (sys_ctl.ms && ms_idle < ACT_MS)
         ms_idle <= ms_idle + 1;        // saturates at hold time
   end
end

a_quiet_before_rx: assert property (@(posedge sys_clk_p) disable iff (off)
   !seen_rx |-> uart_txd && sys_led == 6'd0)
   else
   begin
      $error("uart_txd or sys_led active before the first rx frame");
      fail_cnt++;
   end

a_tx_stb_free: assert property (@(posedge sys_clk_p) disable iff (off)
   tx_byte.stb |-> !tx_busy ##1 !tx_byte.stb)
   else
   begin
      $error("console strobed tx while busy or twice in a row");
      fail_cnt++;
   end

a_no_led_reply: assert property (@(posedge sys_clk_p) disable iff (off)
   l_wait || l_tail |-> !tx_byte.stb)
   else
   begin
      $error("console sent a byte during an 'L' command");
      fail_cnt++;
   end

a_led_follow: assert property (@(posedge sys_clk_p) disable iff (off)
   1'b1 |=> sys_led[5:1] == $past(leds[5:1]))
   else
   begin
      $error("sys_led[5:1] does not follow the led word");
      fail_cnt++;
   end

a_act_on: assert property (@(posedge sys_clk_p) disable iff (off)
   rx_byte.stb |=> sys_led[0])
   else
   begin
      $error("activity led did not light after an rx frame");
      fail_cnt++;
   end

a_act_off: assert property (@(posedge sys_clk_p) disable iff (off)
   ms_idle >= ACT_MS |-> !sys_led[0])
   else
   begin
      $error("activity led still lit after the hold time");
      fail_cnt++;
   end

endmodule

bind sn9_top sn9_properties u_props
(
   .sys_clk_p (sys_clk_p),
   .rst_n     (rst_n),
   .uart_txd  (uart_txd),
   .sys_led   (sys_led),
   .sys_ctl   (sys_ctl),
   .rx_byte   (rx_byte),
   .tx_byte   (tx_byte),
   .tx_busy   (tx_busy),
   .leds      (leds)
);

//--- sn9_tb.sv
//////////////////////////////
// testbench for the sn9 board top
// sends 8N1 frames on uart_rxd, decodes uart_txd into
// a reply queue and checks echo, led word, uptime,
// activity light and button reset
// compile with src.f
//////////////////////////////
`timescale 1ns/1ps
`include "sn9_macros.svh"

module sn9_tb;

localparam int BIT_CLKS   = `SN9_BIT_CLKS;
localparam int FRAME_CLKS = 11 * BIT_CLKS;             // 8N1 plus one idle bit
localparam int US_CLKS    = `SN9_CLOCK_HZ / 1000000;
localparam int MS_CLKS    = `SN9_CLOCK_HZ / 1000;
localparam int N_ECHO     = 16;
localparam int N_FRAMES   = 2 * N_ECHO + 12;           // sent plus received
localparam int ACT_CLKS   = (`SN9_ACT_MS + 1) * MS_CLKS;
localparam int RST_CLKS   = (`SN9_RST_US + 1) * US_CLKS + 8;
localparam int WD_CLKS    = 4 * N_FRAMES * FRAME_CLKS + ACT_CLKS;

logic       sys_clk_p;
logic       rst_n;
logic       reset_btn_n;
logic       uart_rxd;
logic       uart_txd;
logic [5:0] sys_led;

logic [7:0] replies[$];                 // decoded uart_txd bytes
logic [7:0] expect_q[$];                // echo bytes still owed
int         err_cnt = 0;
int         up_cyc = 0;                 // clocks since rst_n release
integer     seed;

sn9_top dut0
(
   .sys_clk_p   (sys_clk_p),
   .rst_n       (rst_n),
   .reset_btn_n (reset_btn_n),
   .uart_rxd    (uart_rxd),
   .uart_txd    (uart_txd),
   .sys_led     (sys_led)
);

initial sys_clk_p = 1'b0;
always #2 sys_clk_p = ~sys_clk_p;       // 4 ns period

always @(posedge sys_clk_p)
   if (rst_n === 1'b1)
      up_cyc <= up_cyc + 1;

// uart_txd decoder sampling at the falling edge
initial
begin : txd_sampler
   logic [7:0] b;
   forever
   begin
      @(negedge sys_clk_p);
      if (rst_n === 1'b1 && uart_txd === 1'b0)
      begin
         repeat (BIT_CLKS / 2) @(negedge sys_clk_p);   // middle of start bit
         for (int i = 0; i < 8; i++)
         begin
            repeat (BIT_CLKS) @(negedge sys_clk_p);
            b[i] = uart_txd;            // lsb first
         end
         repeat (BIT_CLKS) @(negedge sys_clk_p);
         assert (uart_txd === 1'b1)
         else
         begin
            $display("FAILED at %0t: uart_txd stop bit expected 1, received %b",
                     $time, uart_txd);
            err_cnt++;
         end
         replies.push_back(b);
      end
   end
end

task automatic send_byte(input logic [7:0] b);
   logic [9:0] frame;
   frame = {1'b1, b, 1'b0};
   for (int i = 0; i < 11; i++)
   begin
      @(posedge sys_clk_p);
      #1 uart_rxd = (i < 10) ? frame[i] : 1'b1;       // last bit is the gap
      repeat (BIT_CLKS - 1) @(posedge sys_clk_p);
   end
endtask

task automatic take_reply(output logic [7:0] got, output bit ok);
   int waited;
   waited = 0;
   got    = 8'h00;
   while (replies.size() == 0 && waited < 3 * FRAME_CLKS)
   begin
      @(negedge sys_clk_p);
      waited++;
   end
   ok = (replies.size() != 0);
   assert (ok)
   else
   begin
      $display("no byte came back on uart_txd by %0t", $time);
      err_cnt++;
   end
   if (ok)
      got = replies.pop_front();
endtask

task automatic check_reply(input logic [7:0] exp);
   logic [7:0] got;
   bit         ok;
   take_reply(got, ok);
   if (ok)
      assert (got == exp)
      else
      begin
         $display("FAILED at %0t: uart_txd byte expected %02h, received %02h",
                  $time, exp, got);
         err_cnt++;
      end
endtask

// 'L' then the word makes led bits 5:1 show it with nothing sent back
task automatic set_leds(input logic [7:0] val);
   int waited;
   send_byte(8'h4C);
   send_byte(val);
   waited = 0;
   while (sys_led[5:1] !== val[5:1] && waited < 2 * FRAME_CLKS)
   begin
      @(negedge sys_clk_p);
      waited++;
   end
   assert (sys_led[5:1] === val[5:1])
   else
   begin
      $display("FAILED at %0t: sys_led[5:1] expected %02h, received %02h",
               $time, val[5:1], sys_led[5:1]);
      err_cnt++;
   end
   repeat (FRAME_CLKS) @(negedge sys_clk_p);          // room for a stray reply
   assert (replies.size() == 0)
   else
   begin
      $display("console replied to an 'L' command at %0t", $time);
      err_cnt++;
      replies.delete();
   end
endtask

task automatic read_uptime(output int val, output bit ok);
   logic [7:0] hi_b;
   logic [7:0] lo_b;
   bit         ok_hi;
   bit         ok_lo;
   send_byte(8'h54);                    // 'T'
   take_reply(hi_b, ok_hi);
   take_reply(lo_b, ok_lo);
   ok  = ok_hi && ok_lo;
   val = {hi_b, lo_b};                  // high byte first
endtask

initial
begin : run_tests
   logic [7:0] b;
   int         val;
   int         tb_ms;
   bit         ok;
   seed        = 32'hb7f0;
   rst_n       = 1'b0;
   reset_btn_n = 1'b1;
   uart_rxd    = 1'b1;
   repeat (3) @(posedge sys_clk_p);
   #1 rst_n = 1'b1;
   repeat (RST_CLKS) @(posedge sys_clk_p);            // reset stretch
   repeat (FRAME_CLKS) @(posedge sys_clk_p);          // idle line with quiet outputs

   for (int i = 0; i < N_ECHO; i++)
   begin
      b = 8'h4C;
      while (b == 8'h4C || b == 8'h54)
         b = 8'($random(seed));         // no command bytes
      expect_q.push_back(b);
      send_byte(b);
   end
   while (expect_q.size() != 0)
      check_reply(expect_q.pop_front());

   set_leds(8'h2A);
   set_leds(8'hD5);                     // every led bit toggles

   repeat (ACT_CLKS) @(negedge sys_clk_p);            // line idle
   assert (sys_led[0] === 1'b0)
   else
   begin
      $display("FAILED at %0t: sys_led[0] expected 0, received %b", $time, sys_led[0]);
      err_cnt++;
   end

   read_uptime(val, ok);
   tb_ms = up_cyc / MS_CLKS;
   if (ok)
      assert (val >= tb_ms - 1 && val <= tb_ms)
      else
      begin
         $display("FAILED at %0t: uart_txd uptime expected %0d to %0d, received %0d",
                  $time, tb_ms - 1, tb_ms, val);
         err_cnt++;
      end

   set_leds(8'h3E);
   @(posedge sys_clk_p);
   #1 reset_btn_n = 1'b0;               // short button press
   repeat (3) @(posedge sys_clk_p);
   #1 reset_btn_n = 1'b1;
   repeat (RST_CLKS) @(posedge sys_clk_p);
   @(negedge sys_clk_p);
   assert (sys_led === 6'd0)
   else
   begin
      $display("FAILED at %0t: sys_led expected 00, received %02h", $time, sys_led);
      err_cnt++;
   end
   read_uptime(val, ok);
   if (ok)
      assert (val < 2)
      else
      begin
         $display("FAILED at %0t: uart_txd uptime expected 0 to 1, received %0d",
                  $time, val);
         err_cnt++;
      end

   repeat (10) @(posedge sys_clk_p);
   $display("closing: %0d scoreboard errors, %0d assertion failures",
            err_cnt, dut0.u_props.fail_cnt);
   if (err_cnt == 0 && dut0.u_props.fail_cnt == 0)
      $display("Done: no errors");
   else
      $display("Done: errors found");
   $finish;
end

// watchdog sized from the frame count and the activity wait
initial
begin
   repeat (WD_CLKS) @(posedge sys_clk_p);
   $display("watchdog: run did not finish within %0d clocks", WD_CLKS);
   $display("Done: errors found");
   $finish;
end

endmodule

//--- src.f
+incdir+.
sn9_sys_pkg.sv
sn9_con_pkg.sv
sn9_sysctl.sv
sn9_uart_rx.sv
sn9_console.sv
sn9_uart_tx.sv
sn9_led_drv.sv
sn9_top.sv
sn9_properties.sv
sn9_tb.sv
